// ==== design/ctr_defines.svh ====
// Shared sizes for the CTR encryptor; AES-128 only, and the strobe gap must cover cipher latency
`ifndef CTR_DEFINES_SVH
`define CTR_DEFINES_SVH

// Width of the block index and of the start index.
// The counter field itself is 32 bits, so index plus start may carry past this width
`define CTR_INDEX_WIDTH 19

// AES-128 round count
// Changing this does not give another key size, since the key schedule is fixed at 128 bits
`define CTR_ROUNDS 10

// Minimum cycles between data strobes
// Covers pull-to-load, the cipher latency and the ready flop:
// 2 + 11 + 1 = 14 cycles, rounded up for margin
`define CTR_MIN_GAP 16

`endif

// ==== design/ctr_pkg.sv ====
// Block layout and AES byte helpers; byte 0 of the AES state is bits 127:120 of a block
package ctr_pkg;

   // Counter block as the keystream generator builds it
   typedef struct packed {
      logic [31:0] ctr;
      logic [95:0] rsvd;
   } ctr_block_t;

   // One 128-bit block, seen as a counter block or as sixteen state bytes
   // bytes[15] is AES byte 0, bytes[0] is AES byte 15
   typedef union packed {
      ctr_block_t       cb;
      logic [15:0][7:0] bytes;
   } block_u;

   // Forward S-box, row-major, entry 0x00 in the top bits
   localparam logic [2047:0] SBOX_FLAT = {
      128'h637c777bf26b6fc53001672bfed7ab76,
      128'hca82c97dfa5947f0add4a2af9ca472c0,
      128'hb7fd9326363ff7cc34a5e5f171d83115,
      128'h04c723c31896059a071280e2eb27b275,
      128'h09832c1a1b6e5aa0523bd6b329e32f84,
      128'h53d100ed20fcb15b6acbbe394a4c58cf,
      128'hd0efaafb434d338545f9027f503c9fa8,
      128'h51a3408f929d38f5bcb6da2110fff3d2,
      128'hcd0c13ec5f974417c4a77e3d645d1973,
      128'h60814fdc222a908846eeb814de5e0bdb,
      128'he0323a0a4906245cc2d3ac629195e479,
      128'he7c8376d8dd54ea96c56f4ea657aae08,
      128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
      128'h703eb5664803f60e613557b986c11d9e,
      128'he1f8981169d98e949b1e87e9ce5528df,
      128'h8ca1890dbfe6426841992d0fb054bb16
   };

   // AES SubBytes on a single byte
   function automatic logic [7:0] sbox(input logic [7:0] b);
      logic [11:0] base;
      base = 12'(b) << 3;
      return SBOX_FLAT[2047 - base -: 8];
   endfunction

   // Multiply by x in GF(2^8), reduction polynomial 0x11b
   function automatic logic [7:0] xtime(input logic [7:0] b);
      logic [7:0] shifted;
      shifted = {b[6:0], 1'b0};
      if (b[7])
      begin
         shifted = shifted ^ 8'h1b;
      end
      return shifted;
   endfunction

endpackage

// ==== design/aes_key_expand.sv ====
// AES-128 key schedule, one round key per step; o_round_key is the key for the next step
`timescale 1ns/1ps

module aes_key_expand
(
   input  logic         clk,
   input  logic         reset,
   input  logic         i_ld,
   input  logic [127:0] i_key,
   input  logic         i_step,
   output logic [127:0] o_round_key
);

   logic [127:0] rk_q;
   logic [7:0]   rcon_q;
   logic [31:0]  w0, w1, w2, w3;
   logic [31:0]  rot_word;
   logic [31:0]  sub_word;
   logic [31:0]  n0, n1, n2, n3;

   // Next round key from the held one
   always_comb
   begin
      w0 = rk_q[127:96];
      w1 = rk_q[95:64];
      w2 = rk_q[63:32];
      w3 = rk_q[31:0];
      rot_word = {w3[23:0], w3[31:24]};
      sub_word = {ctr_pkg::sbox(rot_word[31:24]), ctr_pkg::sbox(rot_word[23:16]),
                  ctr_pkg::sbox(rot_word[15:8]), ctr_pkg::sbox(rot_word[7:0])};
      n0 = w0 ^ sub_word ^ {rcon_q, 24'h000000};
      n1 = w1 ^ n0;
      n2 = w2 ^ n1;
      n3 = w3 ^ n2;
   end

   assign o_round_key = {n0, n1, n2, n3};

   // Rcon sequence 01, 02, ... 80, 1b, 36
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rcon_q <= 8'h01;
      end
      else if (i_ld)
      begin
         rcon_q <= 8'h01;
      end
      else if (i_step)
      begin
         rcon_q <= ctr_pkg::xtime(rcon_q);
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_ld)
      begin
         rk_q <= i_key;
      end
      else if (i_step)
      begin
         rk_q <= o_round_key;
      end
   end

endmodule

// ==== design/aes_round_core.sv ====
// Iterative AES-128 encryptor; o_done pulses 11 cycles after i_ld, i_key must hold while busy
`timescale 1ns/1ps
`include "ctr_defines.svh"

module aes_round_core
(
   input  logic            clk,
   input  logic            reset,
   input  logic            i_ld,
   input  logic [127:0]    i_key,
   input  ctr_pkg::block_u i_text_in,
   output logic            o_done,
   output logic [127:0]    o_text_out
);

   localparam int RND_W = $clog2(`CTR_ROUNDS + 1);

   ctr_pkg::block_u  state_q;
   ctr_pkg::block_u  next_state;
   logic [RND_W-1:0] round_q;
   logic             busy_q;
   logic             done_q;
   logic             last_round;
   logic [127:0]     round_key;
   logic [7:0]       sub_b   [16];
   logic [7:0]       shift_b [16];
   logic [7:0]       mix_b   [16];

   aes_key_expand u_key_expand
   (
      .clk         (clk),
      .reset       (reset),
      .i_ld        (i_ld),
      .i_key       (i_key),
      .i_step      (busy_q),
      .o_round_key (round_key)
   );

   // Last round has no MixColumns
   assign last_round = (round_q == RND_W'(`CTR_ROUNDS));

   // One full round on the byte view, indices in AES order (i = 4 * col + row)
   always_comb
   begin
      for (int i = 0; i < 16; i++)
      begin
         sub_b[i] = ctr_pkg::sbox(state_q.bytes[15 - i]);
      end
      // Row r rotates left by r columns
      for (int c = 0; c < 4; c++)
      begin
         for (int r = 0; r < 4; r++)
         begin
            shift_b[4 * c + r] = sub_b[4 * ((c + r) % 4) + r];
         end
      end
      for (int c = 0; c < 4; c++)
      begin
         mix_b[4 * c] = ctr_pkg::xtime(shift_b[4 * c]) ^ ctr_pkg::xtime(shift_b[4 * c + 1])
                        ^ shift_b[4 * c + 1] ^ shift_b[4 * c + 2] ^ shift_b[4 * c + 3];
         mix_b[4 * c + 1] = shift_b[4 * c] ^ ctr_pkg::xtime(shift_b[4 * c + 1])
                            ^ ctr_pkg::xtime(shift_b[4 * c + 2]) ^ shift_b[4 * c + 2]
                            ^ shift_b[4 * c + 3];
         mix_b[4 * c + 2] = shift_b[4 * c] ^ shift_b[4 * c + 1]
                            ^ ctr_pkg::xtime(shift_b[4 * c + 2])
                            ^ ctr_pkg::xtime(shift_b[4 * c + 3]) ^ shift_b[4 * c + 3];
         mix_b[4 * c + 3] = ctr_pkg::xtime(shift_b[4 * c]) ^ shift_b[4 * c]
                            ^ shift_b[4 * c + 1] ^ shift_b[4 * c + 2]
                            ^ ctr_pkg::xtime(shift_b[4 * c + 3]);
      end
      // AddRoundKey
      for (int i = 0; i < 16; i++)
      begin
         next_state.bytes[15 - i] = (last_round ? shift_b[i] : mix_b[i])
                                    ^ round_key[127 - 8 * i -: 8];
      end
   end

   // Round sequencing
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         busy_q  <= 1'b0;
         round_q <= '0;
         done_q  <= 1'b0;
      end
      else
      begin
         done_q <= 1'b0;
         if (i_ld)
         begin
            busy_q  <= 1'b1;
            round_q <= RND_W'(1);
         end
         else if (busy_q)
         begin
            round_q <= round_q + 1'b1;
            if (last_round)
            begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end
         end
      end
   end

   // Initial whitening on load, then one round per cycle
   always_ff @(posedge clk)
   begin
      if (i_ld)
      begin
         state_q <= i_text_in ^ i_key;
      end
      else if (busy_q)
      begin
         state_q <= next_state;
      end
   end

   assign o_done     = done_q;
   assign o_text_out = state_q;

   // The keygen only reloads after the previous word was pulled
   a_no_done_on_load: assert property (@(posedge clk) disable iff (reset)
      !(o_done && i_ld));

endmodule

// ==== design/aes_keygen.sv ====
// Keystream prefetch; one word in flight, restart leaves the already loaded block unchanged
`timescale 1ns/1ps
`include "ctr_defines.svh"

module aes_keygen
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        i_go,
   input  logic                        i_pull,
   input  logic                        i_reset_index,
   input  logic                        i_zero_key,
   input  logic [127:0]                i_global_key,
   input  logic [`CTR_INDEX_WIDTH-1:0] i_start_index,
   output logic [127:0]                o_key,
   output logic                        o_rdy
);

   localparam logic ST_IDLE = 1'b0;
   localparam logic ST_WAIT = 1'b1;

   logic                        state_q;
   logic                        core_ld;
   logic                        core_done;
   logic [127:0]                core_text_out;
   logic                        rdy_q;
   logic                        load_now;
   logic [`CTR_INDEX_WIDTH-1:0] index_q;
   ctr_pkg::block_u             ctr_block;
   ctr_pkg::block_u             core_text_in;
   logic [127:0]                key_q;

   aes_round_core u_core
   (
      .clk        (clk),
      .reset      (reset),
      .i_ld       (core_ld),
      .i_key      (i_global_key),
      .i_text_in  (core_text_in),
      .o_done     (core_done),
      .o_text_out (core_text_out)
   );

   assign load_now = (state_q == ST_IDLE) && i_go;

   // Counter block, zero-extended sum so a carry past the index width is kept
   always_comb
   begin
      ctr_block.cb.ctr  = 32'(index_q) + 32'(i_start_index);
      ctr_block.cb.rsvd = '0;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_q <= ST_IDLE;
         core_ld <= 1'b0;
         rdy_q   <= 1'b0;
         index_q <= '0;
      end
      else
      begin
         core_ld <= load_now;
         if (load_now)
         begin
            state_q <= ST_WAIT;
         end
         else if (state_q == ST_WAIT)
         begin
            if (core_done)
            begin
               rdy_q <= 1'b1;
            end
            // Word consumed, fetch the next one
            if (i_pull)
            begin
               rdy_q   <= 1'b0;
               state_q <= ST_IDLE;
            end
         end
         if (i_reset_index)
         begin
            index_q <= '0;
         end
         else if (load_now)
         begin
            index_q <= index_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (load_now)
      begin
         core_text_in <= ctr_block;
      end
      // Bypass stores an all-zero keystream
      if ((state_q == ST_WAIT) && core_done)
      begin
         key_q <= i_zero_key ? '0 : core_text_out;
      end
   end

   assign o_key = key_q;
   assign o_rdy = rdy_q;

   a_pull_when_ready: assert property (@(posedge clk) disable iff (reset)
      i_pull |-> o_rdy);

endmodule

// ==== design/ctr_xor_stage.sv ====
// CTR output XOR; no back-pressure, so strobes must be CTR_MIN_GAP cycles apart
`timescale 1ns/1ps
`include "ctr_defines.svh"

module ctr_xor_stage
(
   input  logic         clk,
   input  logic         reset,
   input  logic         i_valid,
   input  logic [127:0] i_data,
   input  logic [127:0] i_key,
   input  logic         i_key_rdy,
   output logic         o_pull,
   output logic         o_valid,
   output logic [127:0] o_data
);

   localparam int GAP_W = $clog2(`CTR_MIN_GAP + 1);

   logic             valid_q;
   logic [127:0]     data_q;
   logic [GAP_W-1:0] gap_q;

   // Each strobe consumes the waiting keystream word
   assign o_pull = i_valid;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         valid_q <= 1'b0;
         gap_q   <= GAP_W'(`CTR_MIN_GAP);
      end
      else
      begin
         valid_q <= i_valid;
         // Cycles since the last strobe, saturating
         if (i_valid)
         begin
            gap_q <= GAP_W'(1);
         end
         else if (gap_q < GAP_W'(`CTR_MIN_GAP))
         begin
            gap_q <= gap_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_valid)
      begin
         data_q <= i_data ^ i_key;
      end
   end

   assign o_valid = valid_q;
   assign o_data  = data_q;

   a_min_gap: assert property (@(posedge clk) disable iff (reset)
      i_valid |-> (gap_q >= GAP_W'(`CTR_MIN_GAP)));

   a_key_ready: assert property (@(posedge clk) disable iff (reset)
      i_valid |-> i_key_rdy);

endmodule

// ==== design/ctr_crypt_top.sv ====
// AES-128 CTR stream encryptor; one cycle latency, senders keep CTR_MIN_GAP between strobes
`timescale 1ns/1ps
`include "ctr_defines.svh"

module ctr_crypt_top
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic [127:0]                i_key,
   input  logic [`CTR_INDEX_WIDTH-1:0] i_start_index,
   input  logic                        i_restart,
   input  logic                        i_bypass,
   input  logic                        i_valid,
   input  logic [127:0]                i_data,
   output logic                        o_valid,
   output logic [127:0]                o_data
);

   logic         key_rdy;
   logic [127:0] keystream;
   logic         key_pull;

   // Keystream source, always prefetching
   aes_keygen u_keygen
   (
      .clk           (clk),
      .reset         (reset),
      .i_go          (1'b1),
      .i_pull        (key_pull),
      .i_reset_index (i_restart),
      .i_zero_key    (i_bypass),
      .i_global_key  (i_key),
      .i_start_index (i_start_index),
      .o_key         (keystream),
      .o_rdy         (key_rdy)
   );

   ctr_xor_stage u_xor
   (
      .clk       (clk),
      .reset     (reset),
      .i_valid   (i_valid),
      .i_data    (i_data),
      .i_key     (keystream),
      .i_key_rdy (key_rdy),
      .o_pull    (key_pull),
      .o_valid   (o_valid),
      .o_data    (o_data)
   );

endmodule

// ==== tb/tb_ctr_crypt.sv ====
// Key, start index and bypass change only inside reset; strobes are spaced at least CTR_MIN_GAP
`timescale 1ns/1ps
`include "ctr_defines.svh"

module tb_ctr_crypt;

   localparam int RESET_CYCLES = 16;
   localparam int N_TESTS      = 6;
   localparam int MAX_STROBES  = 20;
   localparam int IDX_W        = `CTR_INDEX_WIDTH;
   localparam int CYCLE_LIMIT  = N_TESTS * MAX_STROBES * `CTR_MIN_GAP
                                 + N_TESTS * (RESET_CYCLES + 2 * `CTR_MIN_GAP) + 200;

   logic               clk;
   logic               reset;
   logic [127:0]       i_key;
   logic [IDX_W-1:0]   i_start_index;
   logic               i_restart;
   logic               i_bypass;
   logic               i_valid;
   logic [127:0]       i_data;
   logic               o_valid;
   logic [127:0]       o_data;

   logic [31:0]        lfsr_q;
   logic [127:0]       exp_q [$];
   logic [127:0]       exp_word;
   logic [IDX_W-1:0]   start_v;
   logic               strobe_q;
   int                 ready_idx;
   int                 next_idx;
   int                 error_count;
   int                 check_count;
   int                 tests_failed;
   int                 cycle_count;
   int                 errors_at_start;

   ctr_crypt_top uut
   (
      .clk           (clk),
      .reset         (reset),
      .i_key         (i_key),
      .i_start_index (i_start_index),
      .i_restart     (i_restart),
      .i_bypass      (i_bypass),
      .i_valid       (i_valid),
      .i_data        (i_data),
      .o_valid       (o_valid),
      .o_data        (o_data)
   );

   always
   begin
      #4 clk = ~clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [127:0] draw_bits(input int n);
      logic [127:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_step(lfsr_q);
         v = {v[126:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // Straight AES-128 on a 4x4 state with byte 4*c+r taken from the top of the block
   function automatic logic [127:0] aes_encrypt(input logic [127:0] key, input logic [127:0] pt);
      logic [31:0]  w [0:43];
      logic [7:0]   s [0:3][0:3];
      logic [7:0]   t [0:3][0:3];
      logic [31:0]  tmp;
      logic [7:0]   rc;
      logic [7:0]   a0, a1, a2, a3;
      logic [127:0] ct;
      rc = 8'h01;
      for (int i = 0; i < 4; i++)
      begin
         w[i] = key[127 - 32 * i -: 32];
      end
      for (int i = 4; i < 44; i++)
      begin
         tmp = w[i - 1];
         if (i % 4 == 0)
         begin
            tmp = {ctr_pkg::sbox(tmp[23:16]), ctr_pkg::sbox(tmp[15:8]),
                   ctr_pkg::sbox(tmp[7:0]), ctr_pkg::sbox(tmp[31:24])} ^ {rc, 24'h0};
            rc = ctr_pkg::xtime(rc);
         end
         w[i] = w[i - 4] ^ tmp;
      end
      for (int c = 0; c < 4; c++)
      begin
         for (int r = 0; r < 4; r++)
         begin
            s[r][c] = pt[127 - 8 * (4 * c + r) -: 8] ^ w[c][31 - 8 * r -: 8];
         end
      end
      for (int rnd = 1; rnd <= 10; rnd++)
      begin
         for (int c = 0; c < 4; c++)
         begin
            for (int r = 0; r < 4; r++)
            begin
               t[r][c] = ctr_pkg::sbox(s[r][(c + r) % 4]);
            end
         end
         for (int c = 0; c < 4 && rnd < 10; c++)
         begin
            a0 = t[0][c];
            a1 = t[1][c];
            a2 = t[2][c];
            a3 = t[3][c];
            t[0][c] = ctr_pkg::xtime(a0) ^ ctr_pkg::xtime(a1) ^ a1 ^ a2 ^ a3;
            t[1][c] = a0 ^ ctr_pkg::xtime(a1) ^ ctr_pkg::xtime(a2) ^ a2 ^ a3;
            t[2][c] = a0 ^ a1 ^ ctr_pkg::xtime(a2) ^ ctr_pkg::xtime(a3) ^ a3;
            t[3][c] = ctr_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ ctr_pkg::xtime(a3);
         end
         for (int c = 0; c < 4; c++)
         begin
            for (int r = 0; r < 4; r++)
            begin
               s[r][c] = t[r][c] ^ w[4 * rnd + c][31 - 8 * r -: 8];
            end
         end
      end
      for (int c = 0; c < 4; c++)
      begin
         for (int r = 0; r < 4; r++)
         begin
            ct[127 - 8 * (4 * c + r) -: 8] = s[r][c];
         end
      end
      return ct;
   endfunction

   // Word n encrypts a zero block whose top 32 bits hold n plus start
   function automatic logic [127:0] expected_out(input logic [127:0] data);
      logic [31:0] ctr;
      ctr = 32'(ready_idx) + 32'(i_start_index);
      if (i_bypass)
      begin
         return data;
      end
      return data ^ aes_encrypt(i_key, {ctr, 96'h0});
   endfunction

   task automatic step_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic apply_reset(input logic [127:0] key, input logic [IDX_W-1:0] start,
                              input logic bypass);
      reset         = 1'b1;
      i_key         = key;
      i_start_index = start;
      i_bypass      = bypass;
      i_valid       = 1'b0;
      i_restart     = 1'b0;
      step_cycles(RESET_CYCLES);
      reset     = 1'b0;
      ready_idx = 0;
      next_idx  = 1;
      // First word needs 13 cycles
      step_cycles(`CTR_MIN_GAP);
   endtask

   // One strobe and its gap, with an optional restart after the next load
   task automatic send_word(input logic [127:0] data, input int extra_gap, input bit restart_mid);
      i_valid = 1'b1;
      i_data  = data;
      exp_q.push_back(expected_out(data));
      ready_idx = next_idx;
      next_idx++;
      step_cycles(1);
      i_valid = 1'b0;
      if (restart_mid)
      begin
         step_cycles(`CTR_MIN_GAP / 2);
         i_restart = 1'b1;
         next_idx  = 0;
         step_cycles(1);
         i_restart = 1'b0;
         step_cycles(`CTR_MIN_GAP / 2 - 2 + extra_gap);
      end
      else
      begin
         step_cycles(`CTR_MIN_GAP - 1 + extra_gap);
      end
   endtask

   task automatic expect_quiet(input int n);
      repeat (n)
      begin
         @(negedge clk);
         assert (o_valid === 1'b0)
         else
         begin
            $display("output strobe at %0t ns while in or just out of reset", $time);
            error_count++;
         end
      end
      @(posedge clk);
      #1;
   endtask

   task automatic finish_test(input string name);
      assert (exp_q.size() == 0)
      else
      begin
         $display("%0d expected output words never appeared in %s", exp_q.size(), name);
         error_count++;
         exp_q.delete();
      end
      if (error_count == errors_at_start)
      begin
         $display("test %s: pass", name);
      end
      else
      begin
         $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
         tests_failed++;
      end
      errors_at_start = error_count;
   endtask

   // No output strobe may come from an input strobe taken during reset
   always @(posedge clk)
   begin
      strobe_q = i_valid && !reset;
   end

   // Output must follow each input strobe by exactly one cycle
   always @(negedge clk)
   begin
      assert (o_valid === strobe_q)
      else
      begin
         $display("output strobe at %0t ns is %b, but input strobe one cycle before was %b",
                  $time, o_valid, strobe_q);
         error_count++;
      end
      if (o_valid === 1'b1)
      begin
         assert (exp_q.size() > 0)
         else
         begin
            $display("output word at %0t ns with no expected word waiting", $time);
            error_count++;
         end
         if (exp_q.size() > 0)
         begin
            exp_word = exp_q.pop_front();
            check_count++;
            assert (o_data === exp_word)
            else
            begin
               $display("mismatch at %0t ns: o_data %h, expected %h", $time, o_data, exp_word);
               error_count++;
            end
         end
      end
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      clk             = 1'b0;
      reset           = 1'b1;
      i_key           = '0;
      i_start_index   = '0;
      i_restart       = 1'b0;
      i_bypass        = 1'b0;
      i_valid         = 1'b0;
      i_data          = '0;
      strobe_q        = 1'b0;
      lfsr_q          = 32'h0399_9d24;
      error_count     = 0;
      check_count     = 0;
      tests_failed    = 0;
      errors_at_start = 0;

      // Check the model against FIPS-197 appendix C.1 before the DUT against the model
      assert (aes_encrypt(128'h000102030405060708090a0b0c0d0e0f,
                          128'h00112233445566778899aabbccddeeff)
              === 128'h69c4e0d86a7b0430d8cdb78070b4c55a)
      else
      begin
         $display("reference AES model disagrees with the FIPS-197 example vector");
         error_count++;
      end
      apply_reset(128'h000102030405060708090a0b0c0d0e0f, '0, 1'b0);
      send_word('0, 0, 1'b0);
      finish_test("known answer");

      // Start within 8 of the top so the counter carries into bit 19
      start_v = IDX_W'(draw_bits(3));
      apply_reset(draw_bits(128), ~start_v, 1'b0);
      for (int n = 0; n < MAX_STROBES; n++)
      begin
         send_word(draw_bits(128), 0, 1'b0);
      end
      finish_test("stream sequence");

      apply_reset(draw_bits(128), IDX_W'(draw_bits(IDX_W)), 1'b0);
      for (int n = 0; n < 6; n++)
      begin
         send_word(draw_bits(128), int'(draw_bits(4)), 1'b0);
      end
      finish_test("latency");

      apply_reset(draw_bits(128), IDX_W'(draw_bits(IDX_W)), 1'b0);
      for (int n = 0; n < 8; n++)
      begin
         send_word(draw_bits(128), 0, n == 3);
      end
      finish_test("restart");

      apply_reset(draw_bits(128), IDX_W'(draw_bits(IDX_W)), 1'b1);
      for (int n = 0; n < 8; n++)
      begin
         send_word(draw_bits(128), 0, 1'b0);
      end
      finish_test("bypass");

      // Input strobe held high through reset must not reach the output
      reset   = 1'b1;
      i_valid = 1'b1;
      expect_quiet(RESET_CYCLES);
      i_valid = 1'b0;
      reset   = 1'b0;
      expect_quiet(`CTR_MIN_GAP);
      finish_test("reset state");

      $display("tests run %0d, tests failed %0d, words checked %0d, errors %0d",
               N_TESTS, tests_failed, check_count, error_count);
      if (error_count == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+design
design/ctr_pkg.sv
design/aes_key_expand.sv
design/aes_round_core.sv
design/aes_keygen.sv
design/ctr_xor_stage.sv
design/ctr_crypt_top.sv
tb/tb_ctr_crypt.sv

// ==== Bender.yml ====
package:
  name: ctr_crypt

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ctr_pkg.sv
      - design/aes_key_expand.sv
      - design/aes_round_core.sv
      - design/aes_keygen.sv
      - design/ctr_xor_stage.sv
      - design/ctr_crypt_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_ctr_crypt.sv
